//--- src.f
+incdir+.
cpu_pkg.sv
instruction_decoder.sv
reg_file.sv
alu.sv
program_counter.sv
cpu.sv
tb_cpu.sv

//--- Bender.yml
package:
  name: cpu

sources:
  - include_dirs:
      - .
    files:
      - cpu_pkg.sv
      - instruction_decoder.sv
      - reg_file.sv
      - alu.sv
      - program_counter.sv
      - cpu.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_cpu.sv

//--- tb_cpu.sv
`default_nettype none

`include "cpu_defs.svh"

module tb_cpu
    import cpu_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_INSTR     = 2000;
    localparam int RESET_TIMEOUT = 8;   // cycles

    logic                       CLK;
    logic                       RESET;
    logic [`ADDR_WIDTH-1:0]     instruction;
    wire  [`ADDR_WIDTH-1:0]     pc;
    wire                        reg_write_en;
    wire  [`REG_ADDR_WIDTH-1:0] reg_write_addr;
    wire  [`DATA_WIDTH-1:0]     reg_write_data;

    // reference model state
    logic [`DATA_WIDTH-1:0] model_regs [`NUM_REGS];
    logic [`ADDR_WIDTH-1:0] model_pc;

    int mismatches;
    int timeouts;

    cpu cpu_inst (
        .CLK            (CLK),
        .RESET          (RESET),
        .instruction    (instruction),
        .pc             (pc),
        .reg_write_en   (reg_write_en),
        .reg_write_addr (reg_write_addr),
        .reg_write_data (reg_write_data)
    );

    always #50 CLK = ~CLK;  // 100 ns period

    // mostly kept opcodes, now and then an unsupported one
    function automatic logic [`ADDR_WIDTH-1:0] random_instruction();
        logic [7:0]  op;
        logic [31:0] raw;
        if ($urandom_range(0, 15) == 0)
            op = $urandom_range(8, 11);
        else
        begin
            case ($urandom_range(0, 8))
                0:       op = OP_LOADI;
                1:       op = OP_MOV;
                2:       op = OP_ADD;
                3:       op = OP_SUB;
                4:       op = OP_AND;
                5:       op = OP_OR;
                6:       op = OP_J;
                7:       op = OP_BEQ;
                default: op = OP_BNE;
            endcase
        end
        raw = $urandom();
        return {op, raw[23:0]};
    endfunction

    function automatic logic writes_register(input logic [7:0] op);
        case (op)
            OP_LOADI, OP_MOV, OP_ADD, OP_SUB, OP_AND, OP_OR: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // value the instruction should write, from the model registers
    function automatic logic [`DATA_WIDTH-1:0] model_result(input logic [`ADDR_WIDTH-1:0] instr);
        logic [7:0]             op;
        logic [`DATA_WIDTH-1:0] a;
        logic [`DATA_WIDTH-1:0] b;
        op = instr[`OPCODE_LSB +: 8];
        a  = model_regs[instr[`SRC1_LSB +: `REG_ADDR_WIDTH]];
        b  = model_regs[instr[`SRC2_LSB +: `REG_ADDR_WIDTH]];
        case (op)
            OP_LOADI: return instr[`IMM_LSB +: `DATA_WIDTH];
            OP_MOV:   return b;
            OP_ADD:   return a + b;     // wraps at 256
            OP_SUB:   return a - b;
            OP_AND:   return a & b;
            OP_OR:    return a | b;
            default:  return '0;
        endcase
    endfunction

    function automatic logic [`ADDR_WIDTH-1:0] model_next_pc(input logic [`ADDR_WIDTH-1:0] instr);
        logic [7:0]                    op;
        logic                          same;
        logic                          taken;
        logic signed [`ADDR_WIDTH-1:0] words;
        op    = instr[`OPCODE_LSB +: 8];
        same  = (model_regs[instr[`SRC1_LSB +: `REG_ADDR_WIDTH]]
                 == model_regs[instr[`SRC2_LSB +: `REG_ADDR_WIDTH]]);
        words = $signed(instr[`OFFSET_LSB +: `OFFSET_WIDTH]);
        case (op)
            OP_J:    taken = 1'b1;
            OP_BEQ:  taken = same;
            OP_BNE:  taken = !same;
            default: taken = 1'b0;
        endcase
        if (taken)
            return model_pc + 4 + words * 4;   // relative to the following word
        else
            return model_pc + 4;
    endfunction

    task automatic clear_model();
        for (int i = 0; i < `NUM_REGS; i++)
        begin
            model_regs[i] = '0;
        end
        model_pc = `RESET_PC;
    endtask

    // what the clock edge does to the model
    task automatic apply_instruction(input logic [`ADDR_WIDTH-1:0] instr);
        logic [`ADDR_WIDTH-1:0] next_pc;
        next_pc = model_next_pc(instr);    // sources read before the write
        if (writes_register(instr[`OPCODE_LSB +: 8]))
            model_regs[instr[`DEST_LSB +: `REG_ADDR_WIDTH]] = model_result(instr);
        model_pc = next_pc;
    endtask

    task automatic check_pc();
        if (pc !== model_pc)
        begin
            $display("Mismatch pc: expected %08h, actual %08h", model_pc, pc);
            mismatches++;
        end
    endtask

    task automatic check_outputs(input logic [`ADDR_WIDTH-1:0] instr);
        logic                         expect_write;
        logic [`REG_ADDR_WIDTH-1:0]   expect_addr;
        logic [`DATA_WIDTH-1:0]       expect_data;
        expect_write = writes_register(instr[`OPCODE_LSB +: 8]);
        expect_addr  = instr[`DEST_LSB +: `REG_ADDR_WIDTH];
        expect_data  = model_result(instr);
        check_pc();
        if (reg_write_en !== expect_write)
        begin
            $display("Mismatch reg_write_en: expected %h, actual %h (instruction %08h)",
                     expect_write, reg_write_en, instr);
            mismatches++;
        end
        if (expect_write && reg_write_en === 1'b1)
        begin
            if (reg_write_addr !== expect_addr)
            begin
                $display("Mismatch reg_write_addr: expected %h, actual %h (instruction %08h)",
                         expect_addr, reg_write_addr, instr);
                mismatches++;
            end
            if (reg_write_data !== expect_data)
            begin
                $display("Mismatch reg_write_data: expected %02h, actual %02h (instruction %08h)",
                         expect_data, reg_write_data, instr);
                mismatches++;
            end
        end
    endtask

    initial
    begin
        int                     wait_count;
        logic                   reset_seen;
        logic [`ADDR_WIDTH-1:0] instr;

        void'($urandom(32'h93f3_eb10));
        mismatches  = 0;
        timeouts    = 0;
        CLK         = 1'b0;
        RESET       = 1'b1;
        instruction = '0;   // a loadi, has to stay gated off in reset
        clear_model();

        wait_count = 0;
        reset_seen = 1'b0;
        while (!reset_seen && wait_count < RESET_TIMEOUT)
        begin
            @(negedge CLK);
            wait_count++;
            if (pc === `RESET_PC)
                reset_seen = 1'b1;
        end

        if (!reset_seen)
        begin
            $display("Timeout: pc did not reach the reset value while RESET was high");
            timeouts++;
        end
        else
        begin
            check_pc();
            if (reg_write_en !== 1'b0)
            begin
                $display("Mismatch reg_write_en: expected 0, actual %h during reset",
                         reg_write_en);
                mismatches++;
            end
            @(posedge CLK);     // second reset edge
            RESET <= 1'b0;
            for (int n = 0; n < NUM_INSTR; n++)
            begin
                instr = random_instruction();
                instruction <= instr;
                @(negedge CLK);
                check_outputs(instr);
                @(posedge CLK);
                apply_instruction(instr);
            end
            @(negedge CLK);
            check_pc();         // last instruction's effect on pc
        end

        $display("Errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- cpu.sv
`default_nettype none

`include "cpu_defs.svh"

module cpu
    import cpu_pkg::*;
(
    input  logic                        CLK,
    input  logic                        RESET,
    input  logic [`ADDR_WIDTH-1:0]      instruction,
    output logic [`ADDR_WIDTH-1:0]      pc,
    output logic                        reg_write_en,   // write trace
    output logic [`REG_ADDR_WIDTH-1:0]  reg_write_addr,
    output logic [`DATA_WIDTH-1:0]      reg_write_data
);

    // decoder outputs
    logic [`REG_ADDR_WIDTH-1:0] src1;
    logic [`REG_ADDR_WIDTH-1:0] src2;
    logic [`DATA_WIDTH-1:0]     imm;
    logic [`OFFSET_WIDTH-1:0]   offset;
    alu_op_e                    alu_op;
    logic                       imm_select;
    logic                       negate_b;
    logic                       branch_eq;
    logic                       branch_ne;
    logic                       jump;

    logic [`DATA_WIDTH-1:0]     read_data_1;
    logic [`DATA_WIDTH-1:0]     read_data_2;
    logic                       zero;

    instruction_decoder decoder_inst (
        .RESET        (RESET),
        .instruction  (instruction),
        .src1         (src1),
        .src2         (src2),
        .dest         (reg_write_addr),
        .imm          (imm),
        .offset       (offset),
        .alu_op       (alu_op),
        .imm_select   (imm_select),
        .negate_b     (negate_b),
        .reg_write_en (reg_write_en),
        .branch_eq    (branch_eq),
        .branch_ne    (branch_ne),
        .jump         (jump)
    );

    reg_file reg_file_inst (
        .CLK         (CLK),
        .RESET       (RESET),
        .write_en    (reg_write_en),
        .write_addr  (reg_write_addr),
        .write_data  (reg_write_data),
        .read_addr_1 (src1),
        .read_addr_2 (src2),
        .read_data_1 (read_data_1),
        .read_data_2 (read_data_2)
    );

    alu alu_inst (
        .operand_a  (read_data_1),
        .reg_b      (read_data_2),
        .imm        (imm),
        .imm_select (imm_select),
        .negate_b   (negate_b),
        .alu_op     (alu_op),
        .result     (reg_write_data),   // straight back to the write port
        .zero       (zero)
    );

    program_counter pc_inst (
        .CLK       (CLK),
        .RESET     (RESET),
        .offset    (offset),
        .branch_eq (branch_eq),
        .branch_ne (branch_ne),
        .jump      (jump),
        .zero      (zero),
        .pc        (pc)
    );

endmodule

`default_nettype wire

//--- program_counter.sv
`default_nettype none

`include "cpu_defs.svh"

module program_counter
(
    input  logic                        CLK,
    input  logic                        RESET,
    input  logic [`OFFSET_WIDTH-1:0]    offset,
    input  logic                        branch_eq,
    input  logic                        branch_ne,
    input  logic                        jump,
    input  logic                        zero,
    output logic [`ADDR_WIDTH-1:0]      pc
);

    localparam logic [`ADDR_WIDTH-1:0] STEP     = `PC_STEP;
    localparam logic [`ADDR_WIDTH-1:0] PC_INIT  = `RESET_PC;
    localparam int                     WORD_SHIFT = $clog2(`PC_STEP);

    logic [`ADDR_WIDTH-1:0] pc_plus_step;
    logic [`ADDR_WIDTH-1:0] offset_ext;     // sign extended word offset
    logic [`ADDR_WIDTH-1:0] target;
    logic                   branch_taken;
    logic [`ADDR_WIDTH-1:0] next_pc;

    assign pc_plus_step = pc + STEP;

    assign offset_ext = {{(`ADDR_WIDTH - `OFFSET_WIDTH){offset[`OFFSET_WIDTH-1]}}, offset};

    // branches and jumps are both relative to pc + 4
    assign target = pc_plus_step + (offset_ext << WORD_SHIFT);

    assign branch_taken = (branch_eq & zero) | (branch_ne & ~zero);

    always_comb
    begin
        if (jump)
        begin
            next_pc = target;
        end
        else if (branch_taken)
        begin
            next_pc = target;
        end
        else
        begin
            next_pc = pc_plus_step;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
            pc <= PC_INIT;
        else
            pc <= next_pc;
    end

    // word aligned fetch
    assert property (@(posedge CLK) disable iff (RESET) pc[WORD_SHIFT-1:0] == '0);

endmodule

`default_nettype wire

//--- alu.sv
`default_nettype none

`include "cpu_defs.svh"

module alu
    import cpu_pkg::*;
(
    input  logic [`DATA_WIDTH-1:0]  operand_a,
    input  logic [`DATA_WIDTH-1:0]  reg_b,
    input  logic [`DATA_WIDTH-1:0]  imm,
    input  logic                    imm_select,
    input  logic                    negate_b,
    input  alu_op_e                 alu_op,
    output logic [`DATA_WIDTH-1:0]  result,
    output logic                    zero
);

    logic [`DATA_WIDTH-1:0] reg_b_neg;  // two's complement of reg_b
    logic [`DATA_WIDTH-1:0] reg_b_sel;
    logic [`DATA_WIDTH-1:0] operand_b;

    assign reg_b_neg = ~reg_b + 1'b1;
    assign reg_b_sel = negate_b ? reg_b_neg : reg_b;

    // immediate overrides the register path entirely
    assign operand_b = imm_select ? imm : reg_b_sel;

    always_comb
    begin
        case (alu_op)
            ALU_FWD: result = operand_b;
            ALU_ADD: result = operand_a + operand_b;    // carry dropped
            ALU_AND: result = operand_a & operand_b;
            ALU_OR:  result = operand_a | operand_b;
            default: result = '0;
        endcase
    end

    // for beq/bne this means the sources were equal
    assign zero = (result == '0);

endmodule

`default_nettype wire

//--- reg_file.sv
`default_nettype none

`include "cpu_defs.svh"

module reg_file
(
    input  logic                        CLK,
    input  logic                        RESET,
    input  logic                        write_en,
    input  logic [`REG_ADDR_WIDTH-1:0]  write_addr,
    input  logic [`DATA_WIDTH-1:0]      write_data,
    input  logic [`REG_ADDR_WIDTH-1:0]  read_addr_1,
    input  logic [`REG_ADDR_WIDTH-1:0]  read_addr_2,
    output logic [`DATA_WIDTH-1:0]      read_data_1,
    output logic [`DATA_WIDTH-1:0]      read_data_2
);

    logic [`DATA_WIDTH-1:0] regs [`NUM_REGS];

    // write port
    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            for (int i = 0; i < `NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (write_en)
        begin
            regs[write_addr] <= write_data;
        end
    end

    // read ports, no bypass from a same-cycle write
    assign read_data_1 = regs[read_addr_1];
    assign read_data_2 = regs[read_addr_2];

    // write data comes through decoder and alu, must be resolved
    assert property (
        @(posedge CLK) disable iff (RESET)
        write_en |-> !$isunknown(write_data)
    );

endmodule

`default_nettype wire

//--- instruction_decoder.sv
`default_nettype none

`include "cpu_defs.svh"

module instruction_decoder
    import cpu_pkg::*;
(
    input  logic                        RESET,
    input  logic [`ADDR_WIDTH-1:0]      instruction,
    output logic [`REG_ADDR_WIDTH-1:0]  src1,
    output logic [`REG_ADDR_WIDTH-1:0]  src2,
    output logic [`REG_ADDR_WIDTH-1:0]  dest,
    output logic [`DATA_WIDTH-1:0]      imm,
    output logic [`OFFSET_WIDTH-1:0]    offset,
    output alu_op_e                     alu_op,
    output logic                        imm_select,
    output logic                        negate_b,
    output logic                        reg_write_en,
    output logic                        branch_eq,
    output logic                        branch_ne,
    output logic                        jump
);

    opcode_e opcode;
    logic    write_op;  // opcode writes a register

    // field slicing
    assign opcode = opcode_e'(instruction[`OPCODE_LSB +: $bits(opcode_e)]);
    assign src1   = instruction[`SRC1_LSB +: `REG_ADDR_WIDTH];
    assign src2   = instruction[`SRC2_LSB +: `REG_ADDR_WIDTH];
    assign dest   = instruction[`DEST_LSB +: `REG_ADDR_WIDTH];
    assign imm    = instruction[`IMM_LSB +: `DATA_WIDTH];
    assign offset = instruction[`OFFSET_LSB +: `OFFSET_WIDTH];

    always_comb
    begin
        // unknown codes fall through to a no-op
        alu_op     = ALU_FWD;
        imm_select = 1'b0;
        negate_b   = 1'b0;
        write_op   = 1'b0;
        branch_eq  = 1'b0;
        branch_ne  = 1'b0;
        jump       = 1'b0;
        case (opcode)
            OP_LOADI:
            begin
                imm_select = 1'b1;  // forward the immediate
                write_op   = 1'b1;
            end
            OP_MOV:
            begin
                write_op = 1'b1;    // forward register b
            end
            OP_ADD:
            begin
                alu_op   = ALU_ADD;
                write_op = 1'b1;
            end
            OP_SUB:
            begin
                alu_op   = ALU_ADD;
                negate_b = 1'b1;    // a + (-b)
                write_op = 1'b1;
            end
            OP_AND:
            begin
                alu_op   = ALU_AND;
                write_op = 1'b1;
            end
            OP_OR:
            begin
                alu_op   = ALU_OR;
                write_op = 1'b1;
            end
            OP_J:   jump = 1'b1;
            OP_BEQ:
            begin
                alu_op    = ALU_ADD;    // compare by subtracting
                negate_b  = 1'b1;
                branch_eq = 1'b1;
            end
            OP_BNE:
            begin
                alu_op    = ALU_ADD;
                negate_b  = 1'b1;
                branch_ne = 1'b1;
            end
            default: ;
        endcase
    end

    assign reg_write_en = write_op & ~RESET;    // no writes while in reset

endmodule

`default_nettype wire

//--- cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    // instruction opcodes, gaps are the unsupported codes
    typedef enum logic [7:0] {
        OP_LOADI = 8'd0,
        OP_MOV   = 8'd1,
        OP_ADD   = 8'd2,
        OP_SUB   = 8'd3,
        OP_AND   = 8'd4,
        OP_OR    = 8'd5,
        OP_J     = 8'd6,
        OP_BEQ   = 8'd7,
        OP_BNE   = 8'd12
    } opcode_e;

    // alu function select
    typedef enum logic [1:0] {
        ALU_FWD,    // pass operand b
        ALU_ADD,    // also sub and compare with negated b
        ALU_AND,
        ALU_OR
    } alu_op_e;

endpackage

`default_nettype wire

//--- cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// datapath and address widths
`define DATA_WIDTH      8
`define ADDR_WIDTH      32
`define REG_ADDR_WIDTH  3
`define NUM_REGS        8
`define OFFSET_WIDTH    8

// instruction field positions, lowest bit of each field
`define OPCODE_LSB      24  // 31:24
`define DEST_LSB        16  // 18:16
`define SRC1_LSB        8   // 10:8
`define SRC2_LSB        0   // 2:0
`define IMM_LSB         0   // 7:0
`define OFFSET_LSB      16  // 23:16, shares bits with dest

// program counter
`define PC_STEP         4
`define RESET_PC        0

`endif
